//--- verilog.f
power_pkg.sv
mbus_pkg.sv
sleep_control.sv
mbus_msg_rx.sv
layer_ctrl.sv
mbus_node_top.sv
mbus_node_asserts.sv
tb_mbus_node.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_mbus_node -o sim_tb

out="$(./obj_dir/sim_tb)"
echo "$out"

if grep -q "Simulation completed successfully" <<< "$out"; then
    exit 0
else
    exit 1
fi

//--- tb_mbus_node.sv
`timescale 1ns/1ps

module tb_mbus_node;

    import mbus_pkg::*;

    localparam logic [ADDR_W-1:0] NODE_ADDR = 4'd5;
    localparam int WAIT_MAX = 40;

    logic              clk;
    logic              RESETn;
    logic              mbus_din;
    logic              wakeup_req0;
    logic              wakeup_req1;
    logic              wakeup_req2;
    logic              mbc_isolate;
    logic              mbc_isolate_b;
    logic              mbc_reset;
    logic              mbc_reset_b;
    logic              mbc_sleep;
    logic              mbc_sleep_b;
    logic              system_active;
    logic              wakeup_req_ored;
    logic [DATA_W-1:0] layer_data;
    logic [DATA_W-1:0] layer_count;

    int                errors;
    int                base;
    int                tests;
    logic [31:0]       lcg_state;
    logic [DATA_W-1:0] model_data;   // expected layer contents
    logic [DATA_W-1:0] model_count;
    logic [DATA_W-1:0] byte_val;
    int                src;

    mbus_node_top #(
        .NODE_ADDR (NODE_ADDR)
    ) dut0 (
        .clk             (clk),
        .RESETn          (RESETn),
        .mbus_din        (mbus_din),
        .wakeup_req0     (wakeup_req0),
        .wakeup_req1     (wakeup_req1),
        .wakeup_req2     (wakeup_req2),
        .mbc_isolate     (mbc_isolate),
        .mbc_isolate_b   (mbc_isolate_b),
        .mbc_reset       (mbc_reset),
        .mbc_reset_b     (mbc_reset_b),
        .mbc_sleep       (mbc_sleep),
        .mbc_sleep_b     (mbc_sleep_b),
        .system_active   (system_active),
        .wakeup_req_ored (wakeup_req_ored),
        .layer_data      (layer_data),
        .layer_count     (layer_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] cur);
        return cur * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int total_errs();
        return errors + dut0.asrt0.assert_errs;
    endfunction

    task automatic rand_byte(output logic [DATA_W-1:0] val);
        lcg_state = lcg_next(lcg_state);
        val = lcg_state[23:16];  // upper bits have the longer period
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // start bit, then address, opcode and data MSB first, then one idle bit
    task automatic send_frame(input logic [ADDR_W-1:0] addr, input mbus_op_t op,
                              input logic [DATA_W-1:0] data);
        logic [FRAME_BITS-1:0] bits;
        bits = {addr, op, data};
        mbus_din = 1'b0;
        tick();
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            mbus_din = bits[i];
            tick();
        end
        mbus_din = 1'b1;
        tick();
    endtask

    task automatic set_wake(input int which, input logic val);
        case (which)
            0: wakeup_req0 = val;
            1: wakeup_req1 = val;
            default: wakeup_req2 = val;
        endcase
    endtask

    task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // each control and its inverted twin
    task automatic check_power(input logic iso, input logic rst, input logic slp);
        check_flag("mbc_isolate", mbc_isolate, iso);
        check_flag("mbc_isolate_b", mbc_isolate_b, ~iso);
        check_flag("mbc_reset", mbc_reset, rst);
        check_flag("mbc_reset_b", mbc_reset_b, ~rst);
        check_flag("mbc_sleep", mbc_sleep, slp);
        check_flag("mbc_sleep_b", mbc_sleep_b, ~slp);
    endtask

    task automatic wait_awake();
        int n;
        n = 0;
        while ((mbc_isolate || mbc_reset) && n < WAIT_MAX) begin
            tick();
            n++;
        end
        if (n >= WAIT_MAX) begin
            $display("timeout at %0t ns: gated domain never left isolation", $time);
            errors++;
        end
    endtask

    task automatic wait_asleep();
        int n;
        n = 0;
        while (!mbc_sleep && n < WAIT_MAX) begin
            tick();
            n++;
        end
        if (n >= WAIT_MAX) begin
            $display("timeout at %0t ns: gated domain never went to sleep", $time);
            errors++;
        end
    endtask

    task automatic wait_isolated();
        int n;
        n = 0;
        while (!mbc_isolate && n < WAIT_MAX) begin
            tick();
            n++;
        end
        if (n >= WAIT_MAX) begin
            $display("timeout at %0t ns: isolate never rose", $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %-12s finished with %0d errors", name, total_errs() - base);
        base = total_errs();
    endtask

    initial begin
        RESETn      = 1'b0;
        mbus_din    = 1'b1;
        wakeup_req0 = 1'b0;
        wakeup_req1 = 1'b0;
        wakeup_req2 = 1'b0;
        errors      = 0;
        base        = 0;
        tests       = 0;
        lcg_state   = 32'd11;
        model_data  = '0;
        model_count = '0;
        repeat (16) @(posedge clk);
        #1;
        RESETn = 1'b1;
        tick();

        check_power(1'b1, 1'b1, 1'b1);
        check_flag("wakeup_req_ored", wakeup_req_ored, 1'b0);
        check_val("layer_data", layer_data, 8'h00);
        check_val("layer_count", layer_count, 8'h00);
        report_test("reset");

        // every request once, starting from a random one
        lcg_state = lcg_next(lcg_state);
        for (int r = 0; r < 3; r++) begin
            if (r > 0) begin
                send_frame(NODE_ADDR, OP_SLEEP, 8'h00);
                wait_asleep();
                tick();  // settle in sleep before waking
            end
            src = (int'(lcg_state[23:16]) + r) % 3;
            set_wake(src, 1'b1);
            wait_awake();
            check_flag("wakeup_req_ored", wakeup_req_ored, 1'b1);
            check_power(1'b0, 1'b0, 1'b0);
            // request held while a NOP frame clears any pending sleep request
            send_frame(4'd0, OP_NOP, 8'h00);
            set_wake(src, 1'b0);
            tick();
            check_flag("wakeup_req_ored", wakeup_req_ored, 1'b0);
            check_val("layer_data", layer_data, 8'h00);
            check_val("layer_count", layer_count, 8'h00);
        end
        report_test("wake_req");

        for (int w = 0; w < 4; w++) begin
            rand_byte(byte_val);
            send_frame(NODE_ADDR, OP_WRITE, byte_val);
            model_data  = byte_val;
            model_count = model_count + 8'd1;
            check_val("layer_data", layer_data, model_data);
            check_val("layer_count", layer_count, model_count);
        end
        rand_byte(byte_val);
        send_frame(NODE_ADDR ^ 4'h1, OP_WRITE, byte_val);  // other node
        send_frame(NODE_ADDR, OP_NOP, byte_val);
        check_val("layer_data", layer_data, model_data);
        check_val("layer_count", layer_count, model_count);
        report_test("write");

        send_frame(NODE_ADDR, OP_SLEEP, 8'h00);
        wait_isolated();
        check_flag("mbc_reset", mbc_reset, 1'b0);  // reset still one edge behind
        check_val("layer_data", layer_data, 8'h00);
        check_val("layer_count", layer_count, 8'h00);
        check_val("lc0.data_q", dut0.lc0.data_q, model_data);
        check_val("lc0.count_q", dut0.lc0.count_q, model_count);
        wait_asleep();
        report_test("isolate");

        tick();
        mbus_din = 1'b0;  // bare start bit wakes the node
        tick();
        mbus_din = 1'b1;
        wait_awake();
        model_data  = '0;
        model_count = '0;
        repeat (FRAME_BITS + 1) tick();  // let the receiver finish the idle frame
        check_val("layer_data", layer_data, model_data);
        check_val("layer_count", layer_count, model_count);
        report_test("wake_bus");

        send_frame(NODE_ADDR, OP_SLEEP, 8'h00);
        wait_asleep();
        check_power(1'b1, 1'b1, 1'b1);
        check_flag("system_active", system_active, 1'b0);
        report_test("sleep_frame");

        rand_byte(byte_val);
        send_frame(NODE_ADDR, OP_WRITE, byte_val);
        model_data  = byte_val;
        model_count = 8'd1;
        check_power(1'b0, 1'b0, 1'b0);
        check_val("layer_data", layer_data, model_data);
        check_val("layer_count", layer_count, model_count);
        report_test("sleep_write");

        $display("%0d tests run, %0d check errors, %0d assertion errors",
                 tests, errors, dut0.asrt0.assert_errs);
        if (total_errs() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- mbus_node_asserts.sv
`timescale 1ns/1ps

module mbus_node_asserts (
    input logic                        clk,
    input logic                        RESETn,
    input logic                        mbus_din,
    input logic                        sleep_req,
    input logic                        wakeup_req_ored,
    input logic                        mbc_isolate,
    input logic                        mbc_reset,
    input logic                        mbc_sleep,
    input logic                        system_active,
    input logic [mbus_pkg::DATA_W-1:0] layer_data,
    input logic [mbus_pkg::DATA_W-1:0] layer_count
);

    import mbus_pkg::*;

    int assert_errs = 0;

    // domain comes out of reset asleep, isolated and with a cleared layer
    a_reset_state: assert property (@(posedge clk)
        $rose(RESETn) |-> mbc_isolate && mbc_reset && mbc_sleep &&
                          layer_data == '0 && layer_count == '0)
    else begin
        $error("domain not asleep and cleared after reset release");
        assert_errs++;
    end

    // sleep drops in the very cycle a request or a low bus line shows up
    a_wake_same_cycle: assert property (@(posedge clk) disable iff (!RESETn)
        (wakeup_req_ored || !mbus_din) && $past(mbc_sleep) && mbc_isolate |-> !mbc_sleep)
    else begin
        $error("sleep did not drop in the wake cycle");
        assert_errs++;
    end

    a_wake_order: assert property (@(posedge clk) disable iff (!RESETn)
        $fell(mbc_sleep) && mbc_isolate && mbc_reset
        |-> ##1 mbc_isolate ##1 (!mbc_isolate && mbc_reset) ##1 !mbc_reset)
    else begin
        $error("isolate and reset release out of order after wake");
        assert_errs++;
    end

    // a wake arriving as sleep is reached may pull sleep straight back down
    a_sleep_entry: assert property (@(posedge clk) disable iff (!RESETn)
        $rose(sleep_req) && !mbc_isolate && !wakeup_req_ored
        |-> ##1 (mbc_isolate && !mbc_sleep && !mbc_reset)
            ##1 (mbc_reset && (mbc_sleep || wakeup_req_ored || !mbus_din)))
    else begin
        $error("sleep entry sequence wrong");
        assert_errs++;
    end

    a_system_active: assert property (@(posedge clk) disable iff (!RESETn)
        system_active == !(mbc_sleep && mbc_isolate))
    else begin
        $error("system_active does not follow sleep and isolate");
        assert_errs++;
    end

endmodule

bind mbus_node_top mbus_node_asserts asrt0 (
    .clk             (clk),
    .RESETn          (RESETn),
    .mbus_din        (mbus_din),
    .sleep_req       (sleep_req),
    .wakeup_req_ored (wakeup_req_ored),
    .mbc_isolate     (mbc_isolate),
    .mbc_reset       (mbc_reset),
    .mbc_sleep       (mbc_sleep),
    .system_active   (system_active),
    .layer_data      (layer_data),
    .layer_count     (layer_count)
);

//--- mbus_node_top.sv
`timescale 1ns/1ps

module mbus_node_top #(
    parameter logic [mbus_pkg::ADDR_W-1:0] NODE_ADDR = 4'd5
) (
    input  logic                        clk,
    input  logic                        RESETn,
    input  logic                        mbus_din,
    input  logic                        wakeup_req0,
    input  logic                        wakeup_req1,
    input  logic                        wakeup_req2,
    output logic                        mbc_isolate,
    output logic                        mbc_isolate_b,
    output logic                        mbc_reset,
    output logic                        mbc_reset_b,
    output logic                        mbc_sleep,
    output logic                        mbc_sleep_b,
    output logic                        system_active,
    output logic                        wakeup_req_ored,
    output logic [mbus_pkg::DATA_W-1:0] layer_data,
    output logic [mbus_pkg::DATA_W-1:0] layer_count
);

    import mbus_pkg::*;

    logic              wr_en;
    logic [DATA_W-1:0] wr_data;
    logic              sleep_req;

    // bus side, always on
    mbus_msg_rx #(
        .NODE_ADDR (NODE_ADDR)
    ) rx0 (
        .clk       (clk),
        .RESETn    (RESETn),
        .mbus_din  (mbus_din),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .sleep_req (sleep_req)
    );

    sleep_control sc0 (
        .clk             (clk),
        .RESETn          (RESETn),
        .mbus_din        (mbus_din),
        .sleep_req       (sleep_req),
        .wakeup_req0     (wakeup_req0),
        .wakeup_req1     (wakeup_req1),
        .wakeup_req2     (wakeup_req2),
        .mbc_isolate     (mbc_isolate),
        .mbc_isolate_b   (mbc_isolate_b),
        .mbc_reset       (mbc_reset),
        .mbc_reset_b     (mbc_reset_b),
        .mbc_sleep       (mbc_sleep),
        .mbc_sleep_b     (mbc_sleep_b),
        .system_active   (system_active),
        .wakeup_req_ored (wakeup_req_ored)
    );

    // gated layer side
    layer_ctrl lc0 (
        .clk         (clk),
        .RESETn      (RESETn),
        .mbc_reset   (mbc_reset),
        .mbc_isolate (mbc_isolate),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .layer_data  (layer_data),
        .layer_count (layer_count)
    );

endmodule

//--- layer_ctrl.sv
`timescale 1ns/1ps

module layer_ctrl (
    input  logic                        clk,
    input  logic                        RESETn,
    input  logic                        mbc_reset,
    input  logic                        mbc_isolate,
    input  logic                        wr_en,
    input  logic [mbus_pkg::DATA_W-1:0] wr_data,
    output logic [mbus_pkg::DATA_W-1:0] layer_data,
    output logic [mbus_pkg::DATA_W-1:0] layer_count
);

    import mbus_pkg::*;

    logic              domain_rst;
    logic [DATA_W-1:0] data_q;
    logic [DATA_W-1:0] count_q;

    // gated domain loses state on either reset
    assign domain_rst = ~RESETn | mbc_reset;

    always_ff @(posedge clk) begin
        if (domain_rst) begin
            data_q  <= '0;
            count_q <= '0;
        end else if (wr_en) begin
            data_q  <= wr_data;
            count_q <= count_q + 1'b1;  // wraps
        end
    end

    // isolation cells clamp to zero
    assign layer_data  = mbc_isolate ? '0 : data_q;
    assign layer_count = mbc_isolate ? '0 : count_q;

endmodule

//--- mbus_msg_rx.sv
`timescale 1ns/1ps

module mbus_msg_rx #(
    parameter logic [mbus_pkg::ADDR_W-1:0] NODE_ADDR = 4'd0
) (
    input  logic                        clk,
    input  logic                        RESETn,
    input  logic                        mbus_din,
    output logic                        wr_en,
    output logic [mbus_pkg::DATA_W-1:0] wr_data,
    output logic                        sleep_req
);

    import mbus_pkg::*;

    localparam int CNT_W = $clog2(FRAME_BITS);

    logic                  busy;       // inside a frame, past the start bit
    logic [CNT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-2:0] shift_q;
    logic [FRAME_BITS-1:0] frame;
    logic [ADDR_W-1:0]     frame_addr;
    mbus_op_t              frame_op;
    logic [DATA_W-1:0]     frame_data;
    logic                  last_bit;
    logic                  addr_hit;

    // the final bit is taken straight from the line
    assign frame      = {shift_q, mbus_din};
    assign frame_addr = frame[FRAME_BITS-1 -: ADDR_W];
    assign frame_op   = mbus_op_t'(frame[DATA_W +: OP_W]);
    assign frame_data = frame[DATA_W-1:0];

    assign last_bit = busy && (bit_cnt == CNT_W'(FRAME_BITS - 1));
    assign addr_hit = (frame_addr == NODE_ADDR);

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            busy      <= 1'b0;
            bit_cnt   <= '0;
            wr_en     <= 1'b0;
            sleep_req <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (!busy) begin
                if (!mbus_din) begin  // start bit
                    busy      <= 1'b1;
                    bit_cnt   <= '0;
                    sleep_req <= 1'b0;
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit) begin
                    busy <= 1'b0;
                    if (addr_hit) begin
                        case (frame_op)
                            OP_NOP:   ;
                            OP_WRITE: wr_en <= 1'b1;
                            OP_SLEEP: sleep_req <= 1'b1;  // held until next start bit
                            default:  ;
                        endcase
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            shift_q <= frame[FRAME_BITS-2:0];
        end
        if (last_bit) begin
            wr_data <= frame_data;
        end
    end

endmodule

//--- sleep_control.sv
`timescale 1ns/1ps

module sleep_control (
    input  logic clk,
    input  logic RESETn,
    input  logic mbus_din,
    input  logic sleep_req,
    input  logic wakeup_req0,
    input  logic wakeup_req1,
    input  logic wakeup_req2,
    output logic mbc_isolate,
    output logic mbc_isolate_b,
    output logic mbc_reset,
    output logic mbc_reset_b,
    output logic mbc_sleep,
    output logic mbc_sleep_b,
    output logic system_active,
    output logic wakeup_req_ored
);

    import power_pkg::*;

    power_state_t state;
    power_state_t state_nxt;
    logic         asleep;
    logic         wake;

    assign wakeup_req_ored = wakeup_req0 | wakeup_req1 | wakeup_req2;

    assign asleep = (state == PWR_SLEEP);
    // a falling bus line only counts while the domain is fully asleep
    assign wake   = wakeup_req_ored | (asleep & ~mbus_din);

    always_comb begin
        state_nxt = state;
        case (state)
            PWR_ACTIVE: begin
                if (sleep_req && !wake) begin
                    state_nxt = PWR_ISOLATE;
                end
            end
            PWR_ISOLATE: begin
                state_nxt = wake ? PWR_ACTIVE : PWR_SLEEP;  // abort entry on late wake
            end
            PWR_SLEEP: begin
                if (wake) begin
                    state_nxt = PWR_WAKE;
                end
            end
            PWR_WAKE: begin
                state_nxt = PWR_ACTIVE;
            end
            default: begin
                state_nxt = PWR_RESET_STATE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            state     <= PWR_RESET_STATE;
            mbc_reset <= 1'b1;
        end else begin
            state     <= state_nxt;
            mbc_reset <= mbc_isolate;  // reset trails isolate by one stage
        end
    end

    assign mbc_isolate = (state != PWR_ACTIVE);
    assign mbc_sleep   = asleep & ~wake;  // drops in the wake cycle itself

    assign mbc_isolate_b = ~mbc_isolate;
    assign mbc_reset_b   = ~mbc_reset;
    assign mbc_sleep_b   = ~mbc_sleep;
    assign system_active = mbc_sleep_b | mbc_isolate_b;

endmodule

//--- mbus_pkg.sv
package mbus_pkg;

    localparam int ADDR_W = 4;  // node address field
    localparam int OP_W   = 4;  // opcode field
    localparam int DATA_W = 8;  // payload byte

    // bits following the start bit
    localparam int FRAME_BITS = ADDR_W + OP_W + DATA_W;

    typedef enum logic [OP_W-1:0] {
        OP_NOP   = 4'd0,
        OP_WRITE = 4'd1,
        OP_SLEEP = 4'd2
    } mbus_op_t;

endpackage

//--- power_pkg.sv
package power_pkg;

    // power domain sequencing states
    typedef enum logic [1:0] {
        PWR_ACTIVE  = 2'd0,
        PWR_ISOLATE = 2'd1,
        PWR_SLEEP   = 2'd2,
        PWR_WAKE    = 2'd3
    } power_state_t;

    // domain comes up asleep and isolated
    localparam power_state_t PWR_RESET_STATE = PWR_SLEEP;

endpackage
